//--- Bender.yml
package:
  name: pwm_ctrl

sources:
  # RTL in compile order, package first
  - source/pwm_ctrl_pkg.sv
  - source/frame_parser.sv
  - source/payload_buffer.sv
  - source/command_processor.sv
  - source/pwm_bank.sv
  - source/pwm_ctrl_top.sv

  - target: test
    files:
      - dv/tb_pwm_ctrl.sv

//--- dv/tb_pwm_ctrl.sv
/* Testbench for the PWM controller. Sends command frames over the byte link
   and judges LED, frame error and PWM duty behaviour with assertions */
`timescale 1ns/1ns

module tb_pwm_ctrl
    import pwm_ctrl_pkg::*;
();

    typedef logic [7:0] byte_q_t [$];

    logic              clk;
    logic              rst_n;
    byte_in_t          byte_in;
    logic              led;
    logic              frame_error;
    logic [NUM_CH-1:0] pwm_out;

    logic    led_mark;     // High with the checksum strobe of a good LED frame
    logic    err_mark;     // High with the strobe that must raise frame_error
    logic    led_d;
    logic    err_d;
    logic    exp_led;
    bit      cfg_seen;
    int      gap_max;      // Upper bound of idle cycles after each byte
    int      n_errors;
    int      n_checks;
    string   test_name;
    int      exp_per  [NUM_CH] = '{default: 0};
    int      exp_duty [NUM_CH] = '{default: 0};
    bit      cfgd     [NUM_CH] = '{default: 1'b0};
    byte_q_t pl;

    pwm_ctrl_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .byte_in     (byte_in),
        .led         (led),
        .pwm_out     (pwm_out),
        .frame_error (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ========================================================================
    // Expected LED and error timing
    // ========================================================================
    // Report follows the strobe by one cycle and the LED flips one cycle later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_d   <= 1'b0;
            err_d   <= 1'b0;
            exp_led <= 1'b0;
        end else begin
            led_d <= led_mark;
            err_d <= err_mark;
            if (led_d)
                exp_led <= ~exp_led;
        end
    end

    a_led: assert property (@(posedge clk) disable iff (!rst_n) led == exp_led)
        else begin
            n_errors++;
            $display("ERR %s: led expected %0b actual %0b",
                     test_name, $sampled(exp_led), $sampled(led));
        end

    a_frame_err: assert property (@(posedge clk) disable iff (!rst_n) frame_error == err_d)
        else begin
            n_errors++;
            $display("ERR %s: frame_error expected %0b actual %0b",
                     test_name, $sampled(err_d), $sampled(frame_error));
        end

    // Outputs stay quiet until a configuration has been sent
    a_quiet: assert property (@(posedge clk) disable iff (!rst_n) !cfg_seen |-> pwm_out == '0)
        else begin
            n_errors++;
            $display("ERR %s: pwm_out expected 0x00 actual 0x%02h",
                     test_name, $sampled(pwm_out));
        end

    // ========================================================================
    // Stimulus tasks
    // ========================================================================
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            byte_in.valid <= 1'b0;
            led_mark      <= 1'b0;
            err_mark      <= 1'b0;
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic lmark, input logic emark);
        @(posedge clk);
        byte_in  <= '{data: b, valid: 1'b1};
        led_mark <= lmark;
        err_mark <= emark;
        idle((gap_max == 0) ? 0 : int'($urandom % (gap_max + 1)));
    endtask

    task automatic send_frame(input logic [7:0] cmd, input byte_q_t payload,
                              input bit corrupt);
        logic [7:0] csum;
        logic       good_led;
        csum = cmd ^ 8'(payload.size());
        foreach (payload[i])
            csum ^= payload[i];
        if (corrupt)
            csum ^= 8'h3C;
        good_led = !corrupt && (cmd == CMD_LED_TOGGLE);
        send_byte(SYNC_BYTE, 1'b0, 1'b0);
        send_byte(cmd, 1'b0, 1'b0);
        send_byte(8'(payload.size()), 1'b0, 1'b0);
        foreach (payload[i])
            send_byte(payload[i], 1'b0, 1'b0);
        send_byte(csum, good_led, corrupt);
        idle(10);   // Well above the six idle cycles the processor needs
    endtask

    // Parser drops a length above the buffer depth right after the length byte
    task automatic send_overlong();
        send_byte(SYNC_BYTE, 1'b0, 1'b0);
        send_byte(CMD_LED_TOGGLE, 1'b0, 1'b0);
        send_byte(8'(PAYLOAD_DEPTH + 1 + $urandom % 200), 1'b0, 1'b1);
        idle(10);
    endtask

    task automatic build_cfg(input int ch, input int p, input int d);
        pl = {};
        pl.push_back(8'(ch));
        pl.push_back(p[15:8]);
        pl.push_back(p[7:0]);
        pl.push_back(d[15:8]);
        pl.push_back(d[7:0]);
    endtask

    task automatic config_channel(input int ch, input int p, input int d);
        cfg_seen = 1'b1;
        build_cfg(ch, p, d);
        send_frame(CMD_PWM_CONFIG, pl, 1'b0);
        exp_per[ch]  = p;
        exp_duty[ch] = d;
        cfgd[ch]     = 1'b1;
    endtask

    // ========================================================================
    // Checking tasks
    // ========================================================================
    task automatic wait_led(input logic want);
        int n;
        n = 0;
        while (led !== want && n < 20) begin
            @(negedge clk);
            n++;
        end
        n_checks++;
        if (led !== want) begin
            n_errors++;
            $display("Timeout in %s: led never reached %0b", test_name, want);
        end
    endtask

    // High cycles over one window of P cycles must equal min(D, P)
    task automatic check_channel(input int ch);
        int   p;
        int   d;
        int   n;
        int   hi;
        int   win;
        int   want;
        logic start;
        p = exp_per[ch];
        d = exp_duty[ch];
        if (!cfgd[ch] || p == 0) begin
            win  = 32;
            want = 0;
        end else begin
            win  = p;
            want = (d < p) ? d : p;
            @(negedge clk);
            start = pwm_out[ch];
            n     = 0;
            while (pwm_out[ch] === start && n < 2 * p + 4) begin
                @(negedge clk);
                n++;
            end
        end
        hi = 0;
        repeat (win) begin
            @(negedge clk);
            if (pwm_out[ch] === 1'b1)
                hi++;
        end
        n_checks++;
        a_count: assert (hi == want)
            else begin
                n_errors++;
                $display("ERR %s: ch%0d high cycles expected %0d actual %0d",
                         test_name, ch, want, hi);
            end
    endtask

    task automatic check_all();
        for (int c = 0; c < NUM_CH; c++)
            check_channel(c);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int ch;
        int p;
        int d;
        void'($urandom(32'hae6e));
        rst_n     = 1'b0;
        byte_in   = '0;
        led_mark  = 1'b0;
        err_mark  = 1'b0;
        cfg_seen  = 1'b0;
        gap_max   = 0;
        n_errors  = 0;
        n_checks  = 0;
        test_name = "reset";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        idle(20);

        test_name = "led_toggle";
        pl = {};
        send_frame(CMD_LED_TOGGLE, pl, 1'b0);
        wait_led(1'b1);
        pl.push_back(8'h12);
        pl.push_back(SYNC_BYTE);   // Sync value inside payload is plain data
        send_frame(CMD_LED_TOGGLE, pl, 1'b0);
        wait_led(1'b0);

        test_name = "pwm_duty";
        repeat (4) begin
            ch = $urandom % NUM_CH;
            p  = 1 + $urandom % 24;
            d  = $urandom % (p + 4);
            config_channel(ch, p, d);
            check_all();
        end
        test_name = "period_zero";
        config_channel($urandom % NUM_CH, 0, 1 + $urandom % 16);
        check_all();

        test_name = "bad_frames";
        pl = {};
        send_frame(CMD_LED_TOGGLE, pl, 1'b1);
        build_cfg(0, 5, 3);
        send_frame(CMD_PWM_CONFIG, pl, 1'b1);
        send_overlong();
        build_cfg(1, 7, 2);
        send_frame(8'h33, pl, 1'b0);   // Unknown command has no effect
        wait_led(1'b0);
        check_all();

        test_name = "byte_gaps";
        gap_max = 3;
        for (int c = 0; c < NUM_CH; c++) begin
            if (cfgd[c])
                config_channel(c, exp_per[c], exp_duty[c]);
        end
        check_all();
        pl = {};
        send_frame(CMD_LED_TOGGLE, pl, 1'b0);
        wait_led(1'b1);
        ch = $urandom % NUM_CH;
        p  = 1 + $urandom % 24;
        d  = $urandom % (p + 4);
        config_channel(ch, p, d);
        check_all();

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- source/command_processor.sv
/* Command processor. Toggles the LED or reads a five-byte PWM configuration
   from the payload buffer and hands it to the PWM bank with one strobe */
`timescale 1ns/1ns

module command_processor
    import pwm_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  cmd_evt_t                  cmd_evt,
    output logic [PAYLOAD_ADDR_W-1:0] rd_addr,
    input  logic [7:0]                rd_data,
    output logic                      led,
    output pwm_cfg_t                  cfg,
    output logic                      cfg_update
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_CH,
        S_RD_PER_H,
        S_RD_PER_L,
        S_RD_DUTY_H,
        S_RD_DUTY_L,
        S_EXEC
    } state_t;

    state_t   state;
    pwm_cfg_t cfg_q;   // Assembly register, cfg only moves at the strobe

    // ========================================================================
    // Sequencer
    // ========================================================================
    // Each read state latches the byte addressed in the previous cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            rd_addr    <= '0;
            led        <= 1'b0;
            cfg        <= '0;
            cfg_update <= 1'b0;
        end else begin
            cfg_update <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cmd_evt.done) begin
                        case (cmd_evt.cmd)
                            CMD_LED_TOGGLE: led <= ~led;
                            CMD_PWM_CONFIG: begin
                                // Short payloads are ignored like unknown commands
                                if (cmd_evt.len >= PWM_CFG_LEN) begin
                                    rd_addr <= '0;
                                    state   <= S_RD_CH;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                S_RD_CH: begin
                    rd_addr <= rd_addr + 1'b1;
                    state   <= S_RD_PER_H;
                end
                S_RD_PER_H: begin
                    rd_addr <= rd_addr + 1'b1;
                    state   <= S_RD_PER_L;
                end
                S_RD_PER_L: begin
                    rd_addr <= rd_addr + 1'b1;
                    state   <= S_RD_DUTY_H;
                end
                S_RD_DUTY_H: begin
                    rd_addr <= rd_addr + 1'b1;
                    state   <= S_RD_DUTY_L;
                end
                S_RD_DUTY_L: state <= S_EXEC;     // Last byte, address stays at 4
                S_EXEC: begin
                    cfg        <= cfg_q;
                    cfg_update <= 1'b1;
                    state      <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload fields, big-endian
    always_ff @(posedge clk) begin
        case (state)
            S_RD_CH:     cfg_q.ch            <= rd_data[CH_W-1:0];
            S_RD_PER_H:  cfg_q.period[15:8]  <= rd_data;
            S_RD_PER_L:  cfg_q.period[7:0]   <= rd_data;
            S_RD_DUTY_H: cfg_q.duty[15:8]    <= rd_data;
            S_RD_DUTY_L: cfg_q.duty[7:0]     <= rd_data;
            default: ;
        endcase
    end

    // ========================================================================
    // Checks
    // ========================================================================
    a_upd_single: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_update |=> !cfg_update)
        else $error("cfg_update longer than one cycle");

    // Sender must space frames so a new report never lands mid-sequence
    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_evt.done |-> (state == S_IDLE))
        else $error("frame reported while processor busy");

endmodule

//--- source/frame_parser.sv
/* Byte link frame parser. Hunts for sync, checks length and XOR checksum,
   streams payload bytes into the buffer and reports good frames */
`timescale 1ns/1ns

module frame_parser
    import pwm_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  byte_in_t byte_in,
    output pay_wr_t  pay_wr,
    output cmd_evt_t cmd_evt,
    output logic     frame_error
);

    typedef enum logic [2:0] {
        P_HUNT,
        P_CMD,
        P_LEN,
        P_PAYLOAD,
        P_CSUM
    } state_t;

    state_t                    state;
    logic [7:0]                cmd_q;
    logic [PAYLOAD_ADDR_W:0]   len_q;     // One extra bit so 16 fits
    logic [PAYLOAD_ADDR_W:0]   pay_cnt;
    logic [7:0]                csum_q;    // Running XOR
    logic [PAYLOAD_ADDR_W-1:0] len_rpt;

    // Payload goes straight to the buffer on the accepting strobe
    always_comb begin
        pay_wr.en   = byte_in.valid && (state == P_PAYLOAD);
        pay_wr.addr = pay_cnt[PAYLOAD_ADDR_W-1:0];
        pay_wr.data = byte_in.data;
    end

    // A full 16-byte payload still reads as long enough
    assign len_rpt = (len_q > PAYLOAD_DEPTH - 1) ? '1 : len_q[PAYLOAD_ADDR_W-1:0];

    // ========================================================================
    // Frame FSM
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= P_HUNT;
            cmd_q       <= '0;
            len_q       <= '0;
            pay_cnt     <= '0;
            csum_q      <= '0;
            cmd_evt     <= '0;
            frame_error <= 1'b0;
        end else begin
            cmd_evt.done <= 1'b0;   // Pulses only
            frame_error  <= 1'b0;
            if (byte_in.valid) begin
                case (state)
                    P_HUNT: begin
                        if (byte_in.data == SYNC_BYTE)
                            state <= P_CMD;
                    end
                    P_CMD: begin
                        cmd_q  <= byte_in.data;
                        csum_q <= byte_in.data;      // Checksum starts at the command
                        state  <= P_LEN;
                    end
                    P_LEN: begin
                        if (byte_in.data > PAYLOAD_DEPTH) begin
                            frame_error <= 1'b1;     // Would overrun the buffer
                            state       <= P_HUNT;
                        end else begin
                            len_q   <= byte_in.data[PAYLOAD_ADDR_W:0];
                            csum_q  <= csum_q ^ byte_in.data;
                            pay_cnt <= '0;
                            state   <= (byte_in.data == 8'd0) ? P_CSUM : P_PAYLOAD;
                        end
                    end
                    P_PAYLOAD: begin
                        csum_q  <= csum_q ^ byte_in.data;
                        pay_cnt <= pay_cnt + 1'b1;
                        if (pay_cnt + 1'b1 == len_q)
                            state <= P_CSUM;
                    end
                    P_CSUM: begin
                        if (byte_in.data == csum_q) begin
                            cmd_evt.done <= 1'b1;
                            cmd_evt.cmd  <= cmd_q;
                            cmd_evt.len  <= len_rpt;
                        end else begin
                            frame_error <= 1'b1;
                        end
                        state <= P_HUNT;
                    end
                    default: state <= P_HUNT;
                endcase
            end
        end
    end

    // The payload count must never wrap the buffer address
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pay_wr.en |-> (pay_cnt < PAYLOAD_DEPTH))
        else $error("payload write beyond buffer depth");

endmodule

//--- source/payload_buffer.sv
/* Payload byte store between parser and command processor.
   One registered write port, one combinational read port */
`timescale 1ns/1ns

module payload_buffer
    import pwm_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  pay_wr_t                   pay_wr,
    input  logic [PAYLOAD_ADDR_W-1:0] rd_addr,
    output logic [7:0]                rd_data
);

    logic [7:0] mem [PAYLOAD_DEPTH];

    // ========================================================================
    // Write port
    // ========================================================================
    // Contents survive until the next frame overwrites them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PAYLOAD_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (pay_wr.en) begin
            mem[pay_wr.addr] <= pay_wr.data;
        end
    end

    // ========================================================================
    // Read port
    // ========================================================================
    // Same-cycle read, the processor latches it on the following edge
    always_comb begin
        rd_data = mem[rd_addr];
    end

endmodule

//--- source/pwm_bank.sv
/* Eight independent PWM channels. A cfg_update loads period and duty
   into the addressed channel and restarts its counter */
`timescale 1ns/1ns

module pwm_bank
    import pwm_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  pwm_cfg_t          cfg,
    input  logic              cfg_update,
    output logic [NUM_CH-1:0] pwm_out
);

    logic [PWM_W-1:0] period [NUM_CH];
    logic [PWM_W-1:0] duty   [NUM_CH];
    logic [PWM_W-1:0] cnt    [NUM_CH];

    // ========================================================================
    // Channels
    // ========================================================================
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        logic sel;

        assign sel = cfg_update && (cfg.ch == CH_W'(i));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                period[i] <= '0;   // Period 0 keeps the output low
                duty[i]   <= '0;
                cnt[i]    <= '0;
            end else if (sel) begin
                period[i] <= cfg.period;
                duty[i]   <= cfg.duty;
                cnt[i]    <= '0;   // Fresh cycle on every update
            end else if ((period[i] == '0) || (cnt[i] >= period[i] - 1'b1)) begin
                cnt[i] <= '0;
            end else begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end

        // Duty at or above period gives constant high
        assign pwm_out[i] = (period[i] != '0) && (cnt[i] < duty[i]);
    end

endmodule

//--- source/pwm_ctrl_pkg.sv
/* Shared sizes, command codes and link structs for the PWM controller.
   Imported by every RTL block and by the testbench */
package pwm_ctrl_pkg;

    // ========================================================================
    // Sizes
    // ========================================================================
    localparam int PAYLOAD_DEPTH  = 16;   // Payload buffer capacity in bytes
    localparam int PAYLOAD_ADDR_W = 4;
    localparam int NUM_CH         = 8;    // PWM channels in the bank
    localparam int CH_W           = 3;
    localparam int PWM_W          = 16;   // Period and duty width

    // ========================================================================
    // Frame and command codes
    // ========================================================================
    localparam logic [7:0] SYNC_BYTE      = 8'hA5;
    localparam logic [7:0] CMD_LED_TOGGLE = 8'hFF;
    localparam logic [7:0] CMD_PWM_CONFIG = 8'h04;
    localparam int         PWM_CFG_LEN    = 5;      // Channel, period hi/lo, duty hi/lo

    // ========================================================================
    // Link structs
    // ========================================================================
    // One byte on the input link, data only meaningful with valid
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } byte_in_t;

    // Payload write from parser into the buffer
    typedef struct packed {
        logic                      en;
        logic [PAYLOAD_ADDR_W-1:0] addr;
        logic [7:0]                data;
    } pay_wr_t;

    // Frame complete report, done is a single-cycle pulse
    typedef struct packed {
        logic                      done;
        logic [7:0]                cmd;
        logic [PAYLOAD_ADDR_W-1:0] len;   // Saturates at 15
    } cmd_evt_t;

    // Channel configuration carried with cfg_update
    typedef struct packed {
        logic [CH_W-1:0]  ch;
        logic [PWM_W-1:0] period;
        logic [PWM_W-1:0] duty;
    } pwm_cfg_t;

endpackage

//--- source/pwm_ctrl_top.sv
/* Top level of the PWM controller. Wires the frame parser, payload buffer,
   command processor and PWM bank together */
`timescale 1ns/1ns

module pwm_ctrl_top
    import pwm_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  byte_in_t          byte_in,
    output logic              led,
    output logic [NUM_CH-1:0] pwm_out,
    output logic              frame_error
);

    pay_wr_t                   pay_wr;
    cmd_evt_t                  cmd_evt;
    logic [PAYLOAD_ADDR_W-1:0] rd_addr;
    logic [7:0]                rd_data;
    pwm_cfg_t                  cfg;
    logic                      cfg_update;

    frame_parser u_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .byte_in     (byte_in),
        .pay_wr      (pay_wr),
        .cmd_evt     (cmd_evt),
        .frame_error (frame_error)
    );

    payload_buffer u_buffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pay_wr  (pay_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    command_processor u_proc (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_evt    (cmd_evt),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .led        (led),
        .cfg        (cfg),
        .cfg_update (cfg_update)
    );

    pwm_bank u_pwm (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .cfg_update (cfg_update),
        .pwm_out    (pwm_out)
    );

endmodule

//--- verilog.f
source/pwm_ctrl_pkg.sv
source/frame_parser.sv
source/payload_buffer.sv
source/command_processor.sv
source/pwm_bank.sv
source/pwm_ctrl_top.sv
dv/tb_pwm_ctrl.sv
